//--- Makefile
VERILATOR ?= verilator
TOP       ?= singleCycleCpuTb
RTL_TOP   ?= singleCycleCpu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TB PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlUnit.sv
verilog/aluControl.sv
verilog/alu.sv
verilog/regFile.sv
verilog/immGen.sv
verilog/singleCycleCpu.sv
tb/singleCycleCpuTb.sv

//--- tb/singleCycleCpuTb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module singleCycleCpuTb;

    import cpuPkg::*;

    localparam int ImemWords = 128;
    localparam int ResetCycles = 2;

    logic     clk;
    logic     arstN;
    word_t    instr;
    word_t    pc;
    dmemReq_t dmemReq;
    word_t    dmemRdata;
    retire_t  retire;

    word_t imem [ImemWords];          // Program, built below
    word_t dmem [`DMEM_WORDS];        // Memory seen by the DUT
    word_t initMem [`DMEM_WORDS];     // Seed image for both memories
    word_t modelMem [`DMEM_WORDS];
    word_t modelRegs [`REG_COUNT];
    word_t modelPc;

    int progLen = 0;
    bit progBuilt = 0;
    int mismatchCount = 0;
    int otherErrors = 0;
    int storesSeen = 0;
    int seed = 32'h82aa;

    // Expected behavior of the instruction at modelPc
    word_t    expInstr;
    logic     expRegWrite;
    regAddr_t expRd;
    word_t    expWdata;
    logic     expRead;
    logic     expWrite;
    word_t    expAddr;
    word_t    expStore;
    word_t    expNextPc;

    singleCycleCpu uut (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .pc        (pc),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;        // 10 ns period
    end

    // Combinational memory reads
    assign instr     = imem[(pc >> 2) % ImemWords];
    assign dmemRdata = dmem[wordIndex(dmemReq.addr)];

    function automatic int wordIndex(input word_t addr);
        return int'((addr >> 2) % `DMEM_WORDS);
    endfunction

    function automatic word_t encR(input logic [6:0] f7, input regAddr_t rs2,
                                   input regAddr_t rs1, input logic [2:0] f3,
                                   input regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encLw(input regAddr_t rd, input regAddr_t rs1,
                                    input logic [11:0] off);
        return {off, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t encSw(input regAddr_t rs2, input regAddr_t rs1,
                                    input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t encBeq(input regAddr_t rs1, input regAddr_t rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // R-type result straight from the ISA definition
    function automatic word_t rtypeResult(input logic [6:0] f7, input logic [2:0] f3,
                                          input word_t a, input word_t b);
        case (f3)
            3'b000:  return f7[5] ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input word_t w);
        imem[progLen] = w;
        progLen++;
    endtask

    // Reference model, next-state view
    always_comb begin
        word_t rs1v;
        word_t rs2v;
        word_t immI;
        word_t immS;
        word_t immB;
        expInstr    = imem[(modelPc >> 2) % ImemWords];
        rs1v        = modelRegs[expInstr[19:15]];
        rs2v        = modelRegs[expInstr[24:20]];
        immI        = {{20{expInstr[31]}}, expInstr[31:20]};
        immS        = {{20{expInstr[31]}}, expInstr[31:25], expInstr[11:7]};
        immB        = {{19{expInstr[31]}}, expInstr[31], expInstr[7],
                       expInstr[30:25], expInstr[11:8], 1'b0};
        expRd       = expInstr[11:7];
        expRegWrite = 1'b0;
        expWdata    = '0;
        expRead     = 1'b0;
        expWrite    = 1'b0;
        expAddr     = '0;
        expStore    = rs2v;
        expNextPc   = modelPc + 32'd4;
        case (expInstr[6:0])
            7'b0110011: begin
                expRegWrite = 1'b1;
                expWdata    = rtypeResult(expInstr[31:25], expInstr[14:12], rs1v, rs2v);
            end
            7'b0000011: begin
                expRegWrite = 1'b1;
                expRead     = 1'b1;
                expAddr     = rs1v + immI;
                expWdata    = modelMem[wordIndex(rs1v + immI)];
            end
            7'b0100011: begin
                expWrite = 1'b1;
                expAddr  = rs1v + immS;
            end
            7'b1100011: begin
                if (rs1v == rs2v) expNextPc = modelPc + immB;  // Taken BEQ
            end
            default: ;                // Unsupported opcode retires as a no-op
        endcase
    end

    always @(posedge clk) begin
        if (!arstN) begin
            modelPc <= `PC_RESET;
            for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] <= '0;
            for (int i = 0; i < `DMEM_WORDS; i++) modelMem[i] <= initMem[i];
        end else begin
            modelPc <= expNextPc;
            if (expRegWrite && expRd != '0) modelRegs[expRd] <= expWdata;
            if (expWrite) modelMem[wordIndex(expAddr)] <= expStore;
        end
    end

    // Data memory model
    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) dmem[i] <= initMem[i];
        end else if (dmemReq.write) begin
            dmem[wordIndex(dmemReq.addr)] <= dmemReq.wdata;
            storesSeen <= storesSeen + 1;
        end
    end

    // Quiet outputs while reset is held
    assert property (@(posedge clk) !arstN |->
        (pc == `PC_RESET && !retire.valid && !dmemReq.read && !dmemReq.write))
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: output active in reset, pc %h", $time, pc);
        end

    assert property (@(posedge clk) $rose(arstN) |-> pc == `PC_RESET)
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: first pc %h after reset", $time, pc);
        end

    assert property (@(posedge clk) arstN |->
        pc == modelPc && retire.valid && retire.pc == modelPc)
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: pc %h retire.pc %h expected %h",
                     $time, pc, retire.pc, modelPc);
        end

    assert property (@(posedge clk) arstN |->
        retire.regWrite == expRegWrite &&
        (!expRegWrite || (retire.rd == expRd && retire.wdata == expWdata)))
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: pc %h wb x%0d=%h (we %b) expected x%0d=%h (we %b)",
                     $time, modelPc, retire.rd, retire.wdata, retire.regWrite,
                     expRd, expWdata, expRegWrite);
        end

    assert property (@(posedge clk) arstN |->
        dmemReq.read == expRead && dmemReq.write == expWrite &&
        (!(expRead || expWrite) || dmemReq.addr == expAddr) &&
        (!expWrite || dmemReq.wdata == expStore))
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: pc %h mem rd %b wr %b addr %h data %h expected %b %b %h %h",
                     $time, modelPc, dmemReq.read, dmemReq.write, dmemReq.addr,
                     dmemReq.wdata, expRead, expWrite, expAddr, expStore);
        end

    // Store side effect in the retire report
    assert property (@(posedge clk) arstN |->
        retire.memWrite == expWrite &&
        (!expWrite || (retire.memAddr == expAddr && retire.memWdata == expStore)))
        else begin
            mismatchCount++;
            $display("MISMATCH at %0t: pc %h retire store %b %h %h expected %b %h %h",
                     $time, modelPc, retire.memWrite, retire.memAddr, retire.memWdata,
                     expWrite, expAddr, expStore);
        end

    // Program and memory image
    initial begin
        logic [6:0] opF7 [10];
        logic [2:0] opF3 [10];
        regAddr_t   ra;
        regAddr_t   rb;
        regAddr_t   rd;
        int         idx;
        opF7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
        opF3 = '{3'd0, 3'd0, 3'd1, 3'd5, 3'd5, 3'd6, 3'd7, 3'd4, 3'd2, 3'd3};
        arstN = 1'b0;
        for (int i = 0; i < ImemWords; i++) imem[i] = {i[24:0], 7'b0001111};  // Unsupported
        for (int i = 0; i < `DMEM_WORDS; i++) initMem[i] = $random(seed);
        initMem[0] = 32'h8000_0000;   // Signed edge values
        initMem[1] = 32'h7fff_ffff;
        initMem[2] = 32'hffff_ffff;
        initMem[3] = 32'h0000_0001;
        for (int r = 1; r <= 8; r++) begin
            idx = 4 + (($random(seed) & 32'h7fff_ffff) % (`DMEM_WORDS - 4));
            emit(encLw(regAddr_t'(r), 5'd0, 12'(idx * 4)));
        end
        for (int r = 9; r <= 12; r++) emit(encLw(regAddr_t'(r), 5'd0, 12'((r - 9) * 4)));
        emit(encR(7'h20, 5'd12, 5'd9, 3'd0, 5'd13));   // min - 1 wraps
        emit(encR(7'h20, 5'd12, 5'd9, 3'd5, 5'd14));   // SRA of min
        emit(encR(7'h20, 5'd10, 5'd11, 3'd5, 5'd15));  // SRA by 31
        emit(encR(7'h00, 5'd10, 5'd9, 3'd2, 5'd16));   // SLT min < max
        emit(encR(7'h00, 5'd10, 5'd9, 3'd3, 5'd17));   // SLTU
        emit(encR(7'h00, 5'd12, 5'd11, 3'd2, 5'd18));  // -1 < 1
        emit(encR(7'h00, 5'd12, 5'd11, 3'd3, 5'd19));
        for (int rep = 0; rep < 2; rep++) begin
            for (int k = 0; k < 10; k++) begin
                ra = regAddr_t'(1 + (($random(seed) & 32'h7fff_ffff) % 12));
                rb = regAddr_t'(1 + (($random(seed) & 32'h7fff_ffff) % 12));
                rd = regAddr_t'(13 + (($random(seed) & 32'h7fff_ffff) % 8));
                emit(encR(opF7[k], rb, ra, opF3[k], rd));
            end
        end
        emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));     // Write to x0 is dropped
        emit(encR(7'h00, 5'd3, 5'd0, 3'd0, 5'd21));    // Reads x0
        emit(encR(7'h20, 5'd0, 5'd0, 3'd0, 5'd22));
        emit(encSw(5'd5, 5'd0, 12'd40));
        emit(encLw(5'd23, 5'd0, 12'd40));
        emit(encSw(5'd16, 5'd0, 12'd400));
        emit(encLw(5'd24, 5'd0, 12'd400));
        emit(encBeq(5'd1, 5'd1, 13'd12));              // Taken, skips two
        emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd25));
        emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd26));
        emit(encBeq(5'd9, 5'd10, 13'd8));              // Not taken
        emit(encR(7'h00, 5'd4, 5'd3, 3'd0, 5'd26));
        emit({25'h0ab_cd5a, 7'b1111111});              // Unsupported with rd set
        emit(encR(7'h00, 5'd14, 5'd13, 3'd0, 5'd27));
        progBuilt = 1;

        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        while (modelPc != word_t'(progLen * 4)) @(posedge clk);
        #1;                           // Let the last edge's checks report
        if (storesSeen == 0) begin
            otherErrors++;
            $display("No store reached the data memory during the program");
        end
        $display("Summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (progBuilt);
        repeat (progLen + 20 + ResetCycles) @(posedge clk);
        $display("Timeout: the program did not reach its last instruction");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t          a,
    input  cpuPkg::word_t          b,
    input  cpuPkg::aluOperation_e  aluOperation,
    output cpuPkg::word_t          result,
    output logic                   zero
);

    import cpuPkg::*;

    logic [4:0] shamt;              // Only low 5 bits shift
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluOperation)
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_ADD:  result = a + b;
            ALU_XOR:  result = a ^ b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = word_t'(ltSigned);
            ALU_SLL:  result = a << shamt;
            ALU_SLTU: result = word_t'(ltUnsigned);
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt); // Sign bit fills
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);   // BEQ taken when operands match

endmodule

//--- verilog/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  cpuPkg::aluOp_e         aluOp,
    input  logic [6:0]             funct7,
    input  logic [2:0]             funct3,
    output cpuPkg::aluOperation_e  aluOperation
);

    import cpuPkg::*;

    always_comb begin
        case (aluOp)
            ALUOP_ADD: aluOperation = ALU_ADD;   // LW/SW address
            ALUOP_SUB: aluOperation = ALU_SUB;   // BEQ compare
            ALUOP_FUNCT: begin
                case ({funct7, funct3})
                    10'b0000000_000: aluOperation = ALU_ADD;
                    10'b0100000_000: aluOperation = ALU_SUB;
                    10'b0000000_001: aluOperation = ALU_SLL;
                    10'b0000000_101: aluOperation = ALU_SRL;
                    10'b0100000_101: aluOperation = ALU_SRA;
                    10'b0000000_110: aluOperation = ALU_OR;
                    10'b0000000_111: aluOperation = ALU_AND;
                    10'b0000000_100: aluOperation = ALU_XOR;
                    10'b0000000_010: aluOperation = ALU_SLT;
                    10'b0000000_011: aluOperation = ALU_SLTU;
                    default:         aluOperation = ALU_AND; // Unlisted funct pair
                endcase
            end
            default: aluOperation = ALU_AND;     // Reserved aluOp 2'b11
        endcase
    end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic [6:0]     opcode,  // instr[6:0]
    output cpuPkg::ctrl_t  ctrl
);

    import cpuPkg::*;

    always_comb begin
        ctrl       = '0;            // Unknown opcode becomes a no-op
        ctrl.aluOp = ALUOP_ADD;

        case (opcode)
            OP_RTYPE: begin
                ctrl.aluOp    = ALUOP_FUNCT;
                ctrl.regWrite = 1'b1;
            end
            OP_LOAD: begin
                ctrl.aluOp    = ALUOP_ADD;  // rs1 + imm
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_STORE: begin
                ctrl.aluOp    = ALUOP_ADD;  // rs1 + imm
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.aluOp    = ALUOP_SUB;  // Zero flag means equal
                ctrl.branch   = 1'b1;
            end
            default: begin
                ctrl.aluOp    = ALUOP_ADD;
            end
        endcase
    end

    // A load and a store never share one instruction
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("control decode raised memRead and memWrite for opcode %b", opcode);
    end

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;    // Data, address or instruction word
    typedef logic [4:0]  regAddr_t; // Register index x0..x31

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,     // Register-register ALU ops
        OP_LOAD   = 7'b0000011,     // LW
        OP_STORE  = 7'b0100011,     // SW
        OP_BRANCH = 7'b1100011      // BEQ
    } opcode_e;

    // Main decoder to ALU decoder hint
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,        // Address calculation
        ALUOP_SUB   = 2'b01,        // Branch compare
        ALUOP_FUNCT = 2'b10         // Look at funct7/funct3
    } aluOp_e;

    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_OR   = 4'b0001,
        ALU_ADD  = 4'b0010,
        ALU_XOR  = 4'b0011,
        ALU_SUB  = 4'b0110,
        ALU_SLT  = 4'b0111,
        ALU_SLL  = 4'b1000,
        ALU_SLTU = 4'b1001,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } aluOperation_e;

    typedef struct packed {
        logic   branch;             // BEQ in flight
        logic   memRead;            // Load from data memory
        logic   memWrite;           // Store to data memory
        logic   regWrite;           // Write rd at end of cycle
        logic   aluSrc;             // ALU b from immediate
        logic   memToReg;           // Writeback from load data
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t addr;                // Byte address
        word_t wdata;               // Store data
        logic  read;
        logic  write;               // Applied at the rising edge
    } dmemReq_t;

    typedef struct packed {
        logic     valid;            // One instruction retires this cycle
        word_t    pc;
        logic     regWrite;
        regAddr_t rd;
        word_t    wdata;            // Writeback value
        logic     memWrite;         // Store side effect
        word_t    memAddr;
        word_t    memWdata;
    } retire_t;

endpackage

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address width in bits
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// First fetch address after reset
`define PC_RESET 32'h0000_0000

// Words in the data memory model
`define DMEM_WORDS 256

`endif

//--- verilog/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  cpuPkg::word_t  instr,
    output cpuPkg::word_t  imm
);

    import cpuPkg::*;

    always_comb begin
        case (instr[6:0])
            OP_LOAD:   imm = {{20{instr[31]}}, instr[31:20]};               // I-format
            OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S-format
            OP_BRANCH: begin                                                // B-format
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            default:   imm = '0;    // R-type and unknown
        endcase
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  cpuPkg::regAddr_t  rs1,
    input  cpuPkg::regAddr_t  rs2,
    input  cpuPkg::regAddr_t  rd,
    input  logic              we,
    input  cpuPkg::word_t     wdata,
    output cpuPkg::word_t     rdata1,
    output cpuPkg::word_t     rdata2
);

    import cpuPkg::*;

    word_t regs [`REG_COUNT];       // Entry 0 never written

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;      // x0 writes dropped
        end
    end

    // Reads see the old value until the closing edge
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 reads as zero on both ports whatever was written before
    assert property (@(posedge clk) disable iff (!arstN)
        ((rs1 == '0) |-> (rdata1 == '0)) and ((rs2 == '0) |-> (rdata2 == '0)))
        else $error("x0 read back nonzero");

endmodule

//--- verilog/singleCycleCpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module singleCycleCpu (
    input  logic               clk,
    input  logic               arstN,
    input  cpuPkg::word_t      instr,      // Fetched at pc, same cycle
    output cpuPkg::word_t      pc,
    output cpuPkg::dmemReq_t   dmemReq,
    input  cpuPkg::word_t      dmemRdata,  // Combinational load data
    output cpuPkg::retire_t    retire
);

    import cpuPkg::*;

    localparam int unsigned InstrBytes = `XLEN / 8;

    logic [6:0]    opcode;
    regAddr_t      rs1;
    regAddr_t      rs2;
    regAddr_t      rd;
    logic [2:0]    funct3;
    logic [6:0]    funct7;

    ctrl_t         ctrl;
    aluOperation_e aluOperation;
    word_t         imm;
    word_t         rdata1;
    word_t         rdata2;
    word_t         aluB;
    word_t         aluResult;
    logic          aluZero;
    word_t         wbData;
    logic          branchTaken;
    word_t         pcNext;

    // Instruction fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    controlUnit uControl (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    aluControl uAluControl (
        .aluOp        (ctrl.aluOp),
        .funct7       (funct7),
        .funct3       (funct3),
        .aluOperation (aluOperation)
    );

    immGen uImmGen (
        .instr (instr),
        .imm   (imm)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (ctrl.regWrite),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign aluB = ctrl.aluSrc ? imm : rdata2;       // Immediate for LW/SW

    alu uAlu (
        .a            (rdata1),
        .b            (aluB),
        .aluOperation (aluOperation),
        .result       (aluResult),
        .zero         (aluZero)
    );

    assign wbData = ctrl.memToReg ? dmemRdata : aluResult;

    // Next PC
    assign branchTaken = ctrl.branch && aluZero;    // BEQ only
    assign pcNext      = branchTaken ? (pc + imm) : (pc + word_t'(InstrBytes));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `PC_RESET;
        end else begin
            pc <= pcNext;           // One instruction per edge
        end
    end

    // Data memory request, strobes quiet in reset
    assign dmemReq.addr  = aluResult;
    assign dmemReq.wdata = rdata2;
    assign dmemReq.read  = ctrl.memRead && arstN;
    assign dmemReq.write = ctrl.memWrite && arstN;

    // Retire report for the current instruction
    assign retire.valid    = arstN;
    assign retire.pc       = pc;
    assign retire.regWrite = ctrl.regWrite && arstN;
    assign retire.rd       = rd;
    assign retire.wdata    = wbData;
    assign retire.memWrite = dmemReq.write;
    assign retire.memAddr  = aluResult;
    assign retire.memWdata = rdata2;

    // Fetch address stays on a word boundary across taken branches
    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule
